//--- hw/imul_pkg.sv
package imul_pkg;

  // opcode field width
  localparam int OP_W = 4;

  // flag vector layout, msb first: c o a s z p
  localparam int FLAG_W = 6;

  localparam int FLAG_C = 5;
  localparam int FLAG_O = 4;
  // auxiliary carry, never set by a multiply
  localparam int FLAG_A = 3;
  localparam int FLAG_S = 2;
  localparam int FLAG_Z = 1;
  localparam int FLAG_P = 0;

  // multiply opcodes
  // bit 0 marks the signed form of each pair
  typedef enum logic [OP_W-1:0] {
    // low half of the 128-bit product
    op_mul64     = 4'd0,
    op_imul64    = 4'd1,
    // high half of the 128-bit product
    op_lmul64    = 4'd2,
    op_limul64   = 4'd3,
    // 32x32, low 32 bits zero-extended
    op_mul32     = 4'd4,
    op_imul32    = 4'd5,
    // 32x32, full 64-bit product
    op_mul32_64  = 4'd6,
    op_imul32_64 = 4'd7
  } imul_op_e;

endpackage

//--- hw/imul_decode.sv
module imul_decode (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clk_en,
  input  logic                 en,
  input  imul_pkg::imul_op_e   op,
  input  logic [63:0]          r,
  input  logic [63:0]          c,
  output logic                 d_valid,
  output logic [64:0]          d_r,
  output logic [64:0]          d_c,
  output logic                 d_high,
  output logic                 d_short,
  output logic                 d_narrow,
  output logic                 d_signed
);

  logic        sgn;
  logic        high;
  logic        short_res;
  logic        narrow;
  logic [64:0] r_ext;
  logic [64:0] c_ext;

  always_comb begin
    sgn       = 1'b0;
    high      = 1'b0;
    short_res = 1'b0;
    narrow    = 1'b0;
    case (op)
      imul_pkg::op_mul64: begin
      end
      imul_pkg::op_imul64: begin
        sgn = 1'b1;
      end
      imul_pkg::op_lmul64: begin
        high = 1'b1;
      end
      imul_pkg::op_limul64: begin
        sgn  = 1'b1;
        high = 1'b1;
      end
      imul_pkg::op_mul32: begin
        narrow    = 1'b1;
        short_res = 1'b1;
      end
      imul_pkg::op_imul32: begin
        sgn       = 1'b1;
        narrow    = 1'b1;
        short_res = 1'b1;
      end
      imul_pkg::op_mul32_64: begin
        narrow = 1'b1;
      end
      imul_pkg::op_imul32_64: begin
        sgn    = 1'b1;
        narrow = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // 32-bit forms drop bits 63:32 and extend from bit 31
  assign r_ext = narrow ? {{33{sgn & r[31]}}, r[31:0]} : {sgn & r[63], r};
  assign c_ext = narrow ? {{33{sgn & c[31]}}, c[31:0]} : {sgn & c[63], c};

  always_ff @(posedge clk) begin
    if (rst) begin
      d_valid <= 1'b0;
    end else if (clk_en) begin
      d_valid <= en;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_en) begin
      d_r      <= r_ext;
      d_c      <= c_ext;
      d_high   <= high;
      d_short  <= short_res;
      d_narrow <= narrow;
      d_signed <= sgn;
    end
  end

endmodule

//--- hw/imul_csa_tree.sv
module imul_csa_tree (
  input  logic [64:0]  a,
  input  logic [64:0]  b,
  output logic [129:0] sum,
  output logic [129:0] carry
);

  // 65 partial products plus one correction row
  localparam int ROWS = 66;

  // baugh-wooley constant for 65x65, bits 129 and 65
  localparam logic [129:0] CORR = {1'b1, 63'b0, 1'b1, 65'b0};

  function automatic int rows_after(int n);
    return 2 * (n / 3) + n % 3;
  endfunction

  function automatic int rows_at(int lvl);
    int n;
    n = ROWS;
    for (int i = 0; i < lvl; i++) begin
      n = rows_after(n);
    end
    return n;
  endfunction

  function automatic int level_count();
    int n;
    int l;
    n = ROWS;
    l = 0;
    while (n > 2) begin
      n = rows_after(n);
      l++;
    end
    return l;
  endfunction

  localparam int LEVELS = level_count();

  // row j is a * b[j] shifted by j, sign terms inverted
  function automatic logic [129:0] pp_row(logic [64:0] x, logic [64:0] y, int j);
    logic [129:0] row;
    logic [64:0]  bits;
    bits = x & {65{y[j]}};
    if (j == 64) begin
      bits[63:0] = ~bits[63:0];
    end else begin
      bits[64] = ~bits[64];
    end
    row = '0;
    row[j +: 65] = bits;
    return row;
  endfunction

  logic [129:0] lvl_row [LEVELS+1][ROWS];

  for (genvar j = 0; j < 65; j++) begin : g_pp
    assign lvl_row[0][j] = pp_row(a, b, j);
  end
  assign lvl_row[0][65] = CORR;

  // each level folds groups of three rows into sum and carry
  for (genvar l = 1; l <= LEVELS; l++) begin : g_lvl
    localparam int N = rows_at(l - 1);
    localparam int G = N / 3;

    for (genvar g = 0; g < G; g++) begin : g_csa
      assign lvl_row[l][2*g] = lvl_row[l-1][3*g] ^ lvl_row[l-1][3*g+1] ^
                               lvl_row[l-1][3*g+2];
      assign lvl_row[l][2*g+1] = ((lvl_row[l-1][3*g] & lvl_row[l-1][3*g+1]) |
                                  (lvl_row[l-1][3*g] & lvl_row[l-1][3*g+2]) |
                                  (lvl_row[l-1][3*g+1] & lvl_row[l-1][3*g+2])) << 1;
    end

    // leftover rows pass to the next level
    for (genvar k = 3 * G; k < N; k++) begin : g_pass
      assign lvl_row[l][2*G + k - 3*G] = lvl_row[l-1][k];
    end

    for (genvar k = rows_at(l); k < ROWS; k++) begin : g_idle
      assign lvl_row[l][k] = '0;
    end
  end

  assign sum   = lvl_row[LEVELS][0];
  assign carry = lvl_row[LEVELS][1];

endmodule

//--- hw/imul_execute.sv
module imul_execute (
  input  logic         clk,
  input  logic         rst,
  input  logic         clk_en,
  input  logic         d_valid,
  input  logic [64:0]  d_r,
  input  logic [64:0]  d_c,
  input  logic         d_high,
  input  logic         d_short,
  input  logic         d_narrow,
  input  logic         d_signed,
  output logic         x_valid,
  output logic [129:0] x_sum,
  output logic [129:0] x_carry,
  output logic         x_high,
  output logic         x_short,
  output logic         x_narrow,
  output logic         x_signed
);

  logic [129:0] tree_sum;
  logic [129:0] tree_carry;

  imul_csa_tree u_tree (
    .a     (d_r),
    .b     (d_c),
    .sum   (tree_sum),
    .carry (tree_carry)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      x_valid <= 1'b0;
    end else if (clk_en) begin
      x_valid <= d_valid;
    end
  end

  // product stays redundant until the result stage
  always_ff @(posedge clk) begin
    if (clk_en) begin
      x_sum    <= tree_sum;
      x_carry  <= tree_carry;
      x_high   <= d_high;
      x_short  <= d_short;
      x_narrow <= d_narrow;
      x_signed <= d_signed;
    end
  end

endmodule

//--- hw/imul_result.sv
module imul_result (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        clk_en,
  input  logic                        x_valid,
  input  logic [129:0]                x_sum,
  input  logic [129:0]                x_carry,
  input  logic                        x_high,
  input  logic                        x_short,
  input  logic                        x_narrow,
  input  logic                        x_signed,
  output logic [63:0]                 res,
  output logic [imul_pkg::FLAG_W-1:0] flags,
  output logic                        res_valid
);

  logic [129:0]                p;
  logic [63:0]                 res_n;
  logic [imul_pkg::FLAG_W-1:0] flags_n;

  // final carry-propagate add
  assign p = x_sum + x_carry;

  always_comb begin
    flags_n = '0;
    if (x_high) begin
      res_n = p[127:64];
      flags_n[imul_pkg::FLAG_C] = |p[127:64];
      flags_n[imul_pkg::FLAG_O] = p[127:64] != {64{p[63]}};
      flags_n[imul_pkg::FLAG_S] = p[127];
    end else if (!x_narrow) begin
      res_n = p[63:0];
      flags_n[imul_pkg::FLAG_C] = |p[127:64];
      flags_n[imul_pkg::FLAG_O] = p[127:64] != {64{p[63]}};
      flags_n[imul_pkg::FLAG_S] = p[63];
    end else if (!x_short) begin
      res_n = p[63:0];
      flags_n[imul_pkg::FLAG_C] = |p[63:32];
      flags_n[imul_pkg::FLAG_O] = !(&p[63:31] || ~|p[63:31]);
      flags_n[imul_pkg::FLAG_S] = p[63];
    end else begin
      res_n = {32'b0, p[31:0]};
      flags_n[imul_pkg::FLAG_C] = |p[63:32];
      flags_n[imul_pkg::FLAG_O] = p[63:32] != {32{p[31]}};
      flags_n[imul_pkg::FLAG_S] = p[31];
    end

    // high half: zero over the whole product, parity from the low byte
    if (x_high) begin
      flags_n[imul_pkg::FLAG_Z] = ~|p;
      flags_n[imul_pkg::FLAG_P] = ~^p[7:0];
    end else begin
      flags_n[imul_pkg::FLAG_Z] = ~|res_n;
      flags_n[imul_pkg::FLAG_P] = ~^res_n[7:0];
    end

    flags_n[imul_pkg::FLAG_A] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else if (clk_en) begin
      res_valid <= x_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_en) begin
      res   <= res_n;
      flags <= flags_n;
    end
  end

endmodule

//--- hw/imul_unit.sv
module imul_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        clk_en,
  input  logic                        en,
  input  imul_pkg::imul_op_e          op,
  input  logic [63:0]                 r,
  input  logic [63:0]                 c,
  output logic [63:0]                 res,
  output logic [imul_pkg::FLAG_W-1:0] flags,
  output logic                        res_valid
);

  logic         d_valid;
  logic [64:0]  d_r;
  logic [64:0]  d_c;
  logic         d_high;
  logic         d_short;
  logic         d_narrow;
  logic         d_signed;

  logic         x_valid;
  logic [129:0] x_sum;
  logic [129:0] x_carry;
  logic         x_high;
  logic         x_short;
  logic         x_narrow;
  logic         x_signed;

  imul_decode u_decode (
    .clk      (clk),
    .rst      (rst),
    .clk_en   (clk_en),
    .en       (en),
    .op       (op),
    .r        (r),
    .c        (c),
    .d_valid  (d_valid),
    .d_r      (d_r),
    .d_c      (d_c),
    .d_high   (d_high),
    .d_short  (d_short),
    .d_narrow (d_narrow),
    .d_signed (d_signed)
  );

  imul_execute u_execute (
    .clk      (clk),
    .rst      (rst),
    .clk_en   (clk_en),
    .d_valid  (d_valid),
    .d_r      (d_r),
    .d_c      (d_c),
    .d_high   (d_high),
    .d_short  (d_short),
    .d_narrow (d_narrow),
    .d_signed (d_signed),
    .x_valid  (x_valid),
    .x_sum    (x_sum),
    .x_carry  (x_carry),
    .x_high   (x_high),
    .x_short  (x_short),
    .x_narrow (x_narrow),
    .x_signed (x_signed)
  );

  imul_result u_result (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .x_valid   (x_valid),
    .x_sum     (x_sum),
    .x_carry   (x_carry),
    .x_high    (x_high),
    .x_short   (x_short),
    .x_narrow  (x_narrow),
    .x_signed  (x_signed),
    .res       (res),
    .flags     (flags),
    .res_valid (res_valid)
  );

endmodule

//--- bench/imul_unit_sva.sv
module imul_unit_sva (
  input logic                        clk,
  input logic                        rst,
  input logic                        clk_en,
  input logic [63:0]                 res,
  input logic [imul_pkg::FLAG_W-1:0] flags,
  input logic                        res_valid
);

  valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(res_valid))
    else $error("res_valid is unknown after reset");

  // a frozen pipeline keeps its outputs
  valid_hold: assert property (@(posedge clk) disable iff (rst) !clk_en |=> $stable(res_valid))
    else $error("res_valid changed while clk_en was low");

  data_hold: assert property (@(posedge clk) disable iff (rst)
    (!clk_en && res_valid) |=> ($stable(res) && $stable(flags)))
    else $error("res or flags changed while clk_en was low");

  aux_zero: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> !flags[imul_pkg::FLAG_A])
    else $error("auxiliary carry flag set on a multiply result");

endmodule

bind imul_unit imul_unit_sva u_sva (
  .clk       (clk),
  .rst       (rst),
  .clk_en    (clk_en),
  .res       (res),
  .flags     (flags),
  .res_valid (res_valid)
);

//--- bench/imul_unit_tb.sv
module imul_unit_tb;

  localparam int N_ROWS     = 28;
  localparam int N_DIRECTED = 21;
  // rows from here on get random clk_en stalls
  localparam int STALL_FROM = 14;
  localparam int MAX_CYCLES = 4 * N_ROWS + 40;
  localparam int RES_W      = 64 + imul_pkg::FLAG_W;

  logic                        clk;
  logic                        rst;
  logic                        clk_en;
  logic                        en;
  imul_pkg::imul_op_e          op;
  logic [63:0]                 r;
  logic [63:0]                 c;
  logic [63:0]                 res;
  logic [imul_pkg::FLAG_W-1:0] flags;
  logic                        res_valid;

  // stimulus and expected values, one entry per row
  imul_pkg::imul_op_e          row_op    [N_ROWS];
  logic [63:0]                 row_r     [N_ROWS];
  logic [63:0]                 row_c     [N_ROWS];
  logic [63:0]                 row_res   [N_ROWS];
  logic [imul_pkg::FLAG_W-1:0] row_flags [N_ROWS];
  int                          n_filled;

  int         exp_q [$];
  logic [2:0] valid_pipe;
  int         errors = 0;
  int         checked = 0;
  int         cycles = 0;

  imul_unit u_imul_unit (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .en        (en),
    .op        (op),
    .r         (r),
    .c         (c),
    .res       (res),
    .flags     (flags),
    .res_valid (res_valid)
  );

  always #50 clk = ~clk;

  // full 128-bit product of the extended operands, then the flag rules
  function automatic logic [RES_W-1:0] model_result(imul_pkg::imul_op_e o, logic [63:0] a,
                                                    logic [63:0] b);
    logic                        sgn;
    logic                        narrow;
    logic [127:0]                ea;
    logic [127:0]                eb;
    logic [127:0]                p;
    logic [63:0]                 rv;
    logic [imul_pkg::FLAG_W-1:0] f;
    sgn = (o == imul_pkg::op_imul64) || (o == imul_pkg::op_limul64) ||
          (o == imul_pkg::op_imul32) || (o == imul_pkg::op_imul32_64);
    narrow = (o == imul_pkg::op_mul32) || (o == imul_pkg::op_imul32) ||
             (o == imul_pkg::op_mul32_64) || (o == imul_pkg::op_imul32_64);
    if (narrow) begin
      ea = sgn ? {{96{a[31]}}, a[31:0]} : {96'b0, a[31:0]};
      eb = sgn ? {{96{b[31]}}, b[31:0]} : {96'b0, b[31:0]};
    end else begin
      ea = sgn ? {{64{a[63]}}, a} : {64'b0, a};
      eb = sgn ? {{64{b[63]}}, b} : {64'b0, b};
    end
    p = ea * eb;
    f = '0;
    case (o)
      imul_pkg::op_lmul64, imul_pkg::op_limul64: begin
        rv = p[127:64];
        f[imul_pkg::FLAG_C] = |rv;
        f[imul_pkg::FLAG_O] = rv != {64{p[63]}};
        f[imul_pkg::FLAG_S] = rv[63];
      end
      imul_pkg::op_mul32_64, imul_pkg::op_imul32_64: begin
        rv = p[63:0];
        f[imul_pkg::FLAG_C] = |p[63:32];
        f[imul_pkg::FLAG_O] = !((p[63:31] == '0) || (p[63:31] == '1));
        f[imul_pkg::FLAG_S] = p[63];
      end
      imul_pkg::op_mul32, imul_pkg::op_imul32: begin
        rv = {32'b0, p[31:0]};
        f[imul_pkg::FLAG_C] = |p[63:32];
        f[imul_pkg::FLAG_O] = p[63:32] != {32{p[31]}};
        f[imul_pkg::FLAG_S] = p[31];
      end
      default: begin
        rv = p[63:0];
        f[imul_pkg::FLAG_C] = |p[127:64];
        f[imul_pkg::FLAG_O] = p[127:64] != {64{p[63]}};
        f[imul_pkg::FLAG_S] = p[63];
      end
    endcase
    f[imul_pkg::FLAG_Z] = ~|rv;
    f[imul_pkg::FLAG_P] = ~^rv[7:0];
    // high half looks at the whole product for zero
    if (o == imul_pkg::op_lmul64 || o == imul_pkg::op_limul64) begin
      f[imul_pkg::FLAG_Z] = ~|p;
      f[imul_pkg::FLAG_P] = ~^p[7:0];
    end
    return {f, rv};
  endfunction

  task automatic add_row(imul_pkg::imul_op_e o, logic [63:0] a, logic [63:0] b);
    logic [RES_W-1:0] m;
    m = model_result(o, a, b);
    row_op[n_filled]    = o;
    row_r[n_filled]     = a;
    row_c[n_filled]     = b;
    row_res[n_filled]   = m[63:0];
    row_flags[n_filled] = m[RES_W-1:64];
    n_filled++;
  endtask

  task automatic fill_table();
    add_row(imul_pkg::op_mul64, 64'h0, 64'h0);
    add_row(imul_pkg::op_mul64, 64'h1, 64'hffff_ffff_ffff_ffff);
    add_row(imul_pkg::op_mul64, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff);
    add_row(imul_pkg::op_imul64, 64'hffff_ffff_ffff_ffff, 64'h1);
    add_row(imul_pkg::op_imul64, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff);
    add_row(imul_pkg::op_imul64, 64'hffff_ffff_ffff_fffd, 64'h5);
    add_row(imul_pkg::op_lmul64, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff);
    add_row(imul_pkg::op_lmul64, 64'h1, 64'h1);
    add_row(imul_pkg::op_lmul64, 64'h0, 64'hffff_ffff_ffff_ffff);
    add_row(imul_pkg::op_limul64, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
    add_row(imul_pkg::op_limul64, 64'hffff_ffff_ffff_ffff, 64'h1);
    add_row(imul_pkg::op_limul64, 64'h7fff_ffff_ffff_ffff, 64'h2);
    // 32-bit forms with junk in the upper operand bits
    add_row(imul_pkg::op_mul32, 64'hdead_beef_8000_0000, 64'hffff_ffff_0000_0002);
    add_row(imul_pkg::op_mul32, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff);
    add_row(imul_pkg::op_imul32, 64'h1234_5678_ffff_ffff, 64'habcd_0000_0000_0005);
    add_row(imul_pkg::op_imul32, 64'h0000_0001_8000_0000, 64'hffff_0000_8000_0000);
    add_row(imul_pkg::op_imul32, 64'hffff_ffff_0000_0000, 64'h0123_4567_89ab_cdef);
    add_row(imul_pkg::op_mul32_64, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff);
    add_row(imul_pkg::op_mul32_64, 64'haaaa_0000_0001_0000, 64'h5555_0000_0001_0000);
    add_row(imul_pkg::op_imul32_64, 64'hffff_0000_8000_0000, 64'h0000_ffff_8000_0000);
    add_row(imul_pkg::op_imul32_64, 64'h0000_0001_ffff_ffff, 64'h7);
    for (int i = N_DIRECTED; i < N_ROWS; i++) begin
      add_row(imul_pkg::imul_op_e'(4'($urandom % 8)), {$urandom, $urandom}, {$urandom, $urandom});
    end
  endtask

  // expected res_valid follows accepted strobes through three advancing edges
  always @(posedge clk) begin : check_outputs
    int idx;
    if (rst) begin
      valid_pipe <= '0;
    end else begin
      if (clk_en) begin
        valid_pipe <= {valid_pipe[1:0], en};
      end
      assert (res_valid === valid_pipe[2]) else begin
        errors++;
        $display("CHECK FAILED res_valid: expected %0b actual %0b", valid_pipe[2], res_valid);
      end
      if (res_valid && clk_en) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("a result came out with no operation in flight");
        end
        if (exp_q.size() != 0) begin
          idx = exp_q.pop_front();
          checked++;
          assert (res === row_res[idx]) else begin
            errors++;
            $display("CHECK FAILED row %0d %s res: expected %h actual %h",
                     idx, row_op[idx].name(), row_res[idx], res);
          end
          assert (flags === row_flags[idx]) else begin
            errors++;
            $display("CHECK FAILED row %0d %s flags: expected %b actual %b",
                     idx, row_op[idx].name(), row_flags[idx], flags);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int stall;
    void'($urandom(32'h60a1_87b8));
    clk      = 1'b0;
    rst      = 1'b1;
    clk_en   = 1'b1;
    en       = 1'b0;
    op       = imul_pkg::op_mul64;
    r        = '0;
    c        = '0;
    n_filled = 0;
    fill_table();

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // idle edges, res_valid has to stay low
    repeat (2) @(posedge clk);

    for (int i = 0; i < N_ROWS; i++) begin
      @(posedge clk);
      en     <= 1'b1;
      clk_en <= 1'b1;
      op     <= row_op[i];
      r      <= row_r[i];
      c      <= row_c[i];
      exp_q.push_back(i);
      if (i >= STALL_FROM) begin
        stall = $urandom % 4;
        repeat (stall) begin
          @(posedge clk);
          clk_en <= 1'b0;
        end
      end
    end
    @(posedge clk);
    en     <= 1'b0;
    clk_en <= 1'b1;

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);

    $display("errors: %0d, results checked: %0d of %0d", errors, checked, N_ROWS);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
hw/imul_pkg.sv
hw/imul_decode.sv
hw/imul_csa_tree.sv
hw/imul_execute.sv
hw/imul_result.sv
hw/imul_unit.sv
bench/imul_unit_sva.sv
bench/imul_unit_tb.sv

//--- Makefile
# Verilator build and run for the multiply unit

VERILATOR ?= verilator
TOP       ?= imul_unit_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SRCS := $(wildcard hw/*.sv bench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
